// File: vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

   // ------------------------------------------------------------
   // default video timing, 640x480 at a 36 MHz pixel clock
   // ------------------------------------------------------------
   localparam logic [9:0] def_h_active = 10'd640;
   localparam logic [9:0] def_v_active = 10'd480;

   // horizontal blanking lengths in pixels
   localparam logic [9:0] def_h_fp     = 10'd32;
   localparam logic [9:0] def_h_sync   = 10'd48;
   localparam logic [9:0] def_h_bp     = 10'd112;

   // vertical blanking lengths in lines
   localparam logic [9:0] def_v_fp     = 10'd1;
   localparam logic [9:0] def_v_sync   = 10'd3;
   localparam logic [9:0] def_v_bp     = 10'd25;

   // ------------------------------------------------------------
   // position and sync streams shared by all blocks
   // ------------------------------------------------------------
   // x and y read zero while active is low
   typedef struct packed {
      logic       active;
      logic [9:0] x;
      logic [9:0] y;
   } pos_t;

   // syncs are active low
   // frame_start marks both counters at zero
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic frame_start;
   } sync_t;

endpackage

`default_nettype wire

// File: pixel_pkg.sv
`default_nettype none

package pixel_pkg;

   // one bit per channel
   typedef struct packed {
      logic r;
      logic g;
      logic b;
   } rgb_t;

   // how the sprite lands on the bars
   typedef enum logic [1:0] {
      bars_only        = 2'd0,
      sprite_over_bars = 2'd1,
      sprite_xor_bars  = 2'd2,
      sprite_only      = 2'd3
   } mix_mode_t;

   // ------------------------------------------------------------
   // standard color bars, left to right
   // ------------------------------------------------------------
   // white yellow cyan green magenta red blue black
   localparam rgb_t [0:7] bar_table = '{
      3'b111,
      3'b110,
      3'b011,
      3'b010,
      3'b101,
      3'b100,
      3'b001,
      3'b000
   };

endpackage

`default_nettype wire

// File: vga_sync.sv
`default_nettype none

module vga_sync #(
   parameter logic [9:0] h_active = vga_timing_pkg::def_h_active,
   parameter logic [9:0] v_active = vga_timing_pkg::def_v_active,
   parameter logic [9:0] h_fp     = vga_timing_pkg::def_h_fp,
   parameter logic [9:0] h_sync   = vga_timing_pkg::def_h_sync,
   parameter logic [9:0] h_bp     = vga_timing_pkg::def_h_bp,
   parameter logic [9:0] v_fp     = vga_timing_pkg::def_v_fp,
   parameter logic [9:0] v_sync   = vga_timing_pkg::def_v_sync,
   parameter logic [9:0] v_bp     = vga_timing_pkg::def_v_bp
) (
   input  wire logic                  clk_36MHz,
   input  wire logic                  rst,
   input  wire pixel_pkg::rgb_t       mix_rgb,
   output vga_timing_pkg::pos_t       pos,
   output vga_timing_pkg::sync_t      sync,
   output logic                       red,
   output logic                       green,
   output logic                       blue
);

   // blanking comes first on both axes, then active video
   localparam logic [9:0] h_blank = h_fp + h_sync + h_bp;
   localparam logic [9:0] v_blank = v_fp + v_sync + v_bp;
   localparam logic [9:0] h_total = h_blank + h_active;
   localparam logic [9:0] v_total = v_blank + v_active;

   logic [9:0] hc;
   logic [9:0] vc;
   logic       active_now;

   // ------------------------------------------------------------
   // line and frame counters
   // ------------------------------------------------------------
   always_ff @(posedge clk_36MHz)
   begin
      if (rst)
      begin
         hc <= '0;
         vc <= '0;
      end
      else if (hc == h_total - 10'd1)
      begin
         // end of line, step to the next one
         hc <= '0;
         if (vc == v_total - 10'd1)
            vc <= '0;
         else
            vc <= vc + 10'd1;
      end
      else
      begin
         hc <= hc + 10'd1;
      end
   end

   // ------------------------------------------------------------
   // sync pulses straight from the counters
   // ------------------------------------------------------------
   // low only inside the sync window after front porch
   assign sync.hsync       = !((hc >= h_fp) && (hc < h_fp + h_sync));
   assign sync.vsync       = !((vc >= v_fp) && (vc < v_fp + v_sync));
   assign sync.frame_start = (hc == 10'd0) && (vc == 10'd0);

   // active once all blanking on both axes is past
   assign active_now = (hc >= h_blank) && (vc >= v_blank);

   // ------------------------------------------------------------
   // registered position and blanked color pins
   // ------------------------------------------------------------
   always_ff @(posedge clk_36MHz)
   begin
      if (rst)
      begin
         pos <= '0;
      end
      else
      begin
         pos.active <= active_now;
         // zero outside active video
         pos.x <= active_now ? hc - h_blank : 10'd0;
         pos.y <= active_now ? vc - v_blank : 10'd0;
      end
   end

   // color follows pos by one cycle
   always_ff @(posedge clk_36MHz)
   begin
      if (rst || !pos.active)
      begin
         red   <= 1'b0;
         green <= 1'b0;
         blue  <= 1'b0;
      end
      else
      begin
         red   <= mix_rgb.r;
         green <= mix_rgb.g;
         blue  <= mix_rgb.b;
      end
   end

endmodule

`default_nettype wire

// File: bar_pattern.sv
`default_nettype none

module bar_pattern #(
   parameter logic [9:0] bar_width = 10'd80
) (
   input  wire logic                 clk_36MHz,
   input  wire logic                 rst,
   input  wire vga_timing_pkg::pos_t pos,
   output pixel_pkg::rgb_t           bar_rgb
);

   // pixels seen so far in the current bar
   logic [9:0] bar_cnt;
   // which of the eight bars the current pixel falls in
   logic [2:0] bar_idx;

   // ------------------------------------------------------------
   // running x / bar_width without a divider
   // ------------------------------------------------------------
   // state holds the count of active pixels before this one
   always_ff @(posedge clk_36MHz)
   begin
      if (rst || !pos.active)
      begin
         // blanking restarts the line
         bar_cnt <= '0;
         bar_idx <= '0;
      end
      else if (bar_cnt == bar_width - 10'd1)
      begin
         bar_cnt <= '0;
         bar_idx <= bar_idx + 3'd1;
      end
      else
      begin
         bar_cnt <= bar_cnt + 10'd1;
      end
   end

   // table lookup for the pixel of this cycle
   assign bar_rgb = pixel_pkg::bar_table[bar_idx];

endmodule

`default_nettype wire

// File: sprite_box.sv
`default_nettype none

module sprite_box #(
   parameter logic [9:0] h_active    = vga_timing_pkg::def_h_active,
   parameter logic [9:0] v_active    = vga_timing_pkg::def_v_active,
   parameter logic [9:0] sprite_size = 10'd32
) (
   input  wire logic                  clk_36MHz,
   input  wire logic                  rst,
   input  wire vga_timing_pkg::pos_t  pos,
   input  wire vga_timing_pkg::sync_t sync,
   output logic                       hit
);

   // far limits for the top left corner
   localparam logic [9:0] x_max = h_active - sprite_size;
   localparam logic [9:0] y_max = v_active - sprite_size;

   // corner of the square
   logic [9:0] sx;
   logic [9:0] sy;
   // 1 means right, 1 means down
   logic       dir_x;
   logic       dir_y;

   // ------------------------------------------------------------
   // motion, one pixel per frame on each axis
   // ------------------------------------------------------------
   always_ff @(posedge clk_36MHz)
   begin
      if (rst)
      begin
         sx    <= '0;
         sy    <= '0;
         dir_x <= 1'b1;
         dir_y <= 1'b1;
      end
      else if (sync.frame_start)
      begin
         // horizontal axis
         if (dir_x)
         begin
            if (sx >= x_max)
            begin
               // bounce off the right edge
               dir_x <= 1'b0;
               sx    <= sx - 10'd1;
            end
            else
               sx <= sx + 10'd1;
         end
         else if (sx == 10'd0)
         begin
            // bounce off the left edge
            dir_x <= 1'b1;
            sx    <= sx + 10'd1;
         end
         else
            sx <= sx - 10'd1;

         // vertical axis
         if (dir_y)
         begin
            if (sy >= y_max)
            begin
               dir_y <= 1'b0;
               sy    <= sy - 10'd1;
            end
            else
               sy <= sy + 10'd1;
         end
         else if (sy == 10'd0)
         begin
            dir_y <= 1'b1;
            sy    <= sy + 10'd1;
         end
         else
            sy <= sy - 10'd1;
      end
   end

   // ------------------------------------------------------------
   // per pixel hit test against the square
   // ------------------------------------------------------------
   assign hit = pos.active
                && (pos.x >= sx) && (pos.x < sx + sprite_size)
                && (pos.y >= sy) && (pos.y < sy + sprite_size);

endmodule

`default_nettype wire

// File: pixel_mixer.sv
`default_nettype none

module pixel_mixer (
   input  wire logic                  clk_36MHz,
   input  wire logic                  rst,
   input  wire pixel_pkg::mix_mode_t  mode,
   input  wire pixel_pkg::rgb_t       sprite_rgb,
   input  wire vga_timing_pkg::sync_t sync,
   input  wire pixel_pkg::rgb_t       bar_rgb,
   input  wire logic                  hit,
   output pixel_pkg::rgb_t            mix_rgb
);

   // mode held for a whole frame
   pixel_pkg::mix_mode_t mode_q;

   // sampled only at frame start, which lies in blanking
   always_ff @(posedge clk_36MHz)
   begin
      if (rst)
         mode_q <= pixel_pkg::bars_only;
      else if (sync.frame_start)
         mode_q <= mode;
   end

   // ------------------------------------------------------------
   // merge rule
   // ------------------------------------------------------------
   always_comb
   begin
      case (mode_q)
         pixel_pkg::sprite_over_bars:
            mix_rgb = hit ? sprite_rgb : bar_rgb;
         pixel_pkg::sprite_xor_bars:
            mix_rgb = hit ? (bar_rgb ^ sprite_rgb) : bar_rgb;
         pixel_pkg::sprite_only:
            // black around the square
            mix_rgb = hit ? sprite_rgb : 3'b000;
         default:
            mix_rgb = bar_rgb;
      endcase
   end

endmodule

`default_nettype wire

// File: vga_top.sv
`default_nettype none

module vga_top #(
   parameter logic [9:0] h_active    = vga_timing_pkg::def_h_active,
   parameter logic [9:0] v_active    = vga_timing_pkg::def_v_active,
   parameter logic [9:0] h_fp        = vga_timing_pkg::def_h_fp,
   parameter logic [9:0] h_sync      = vga_timing_pkg::def_h_sync,
   parameter logic [9:0] h_bp        = vga_timing_pkg::def_h_bp,
   parameter logic [9:0] v_fp        = vga_timing_pkg::def_v_fp,
   parameter logic [9:0] v_sync      = vga_timing_pkg::def_v_sync,
   parameter logic [9:0] v_bp        = vga_timing_pkg::def_v_bp,
   parameter logic [9:0] sprite_size = 10'd32
) (
   input  wire logic                 clk_36MHz,
   input  wire logic                 rst,
   input  wire pixel_pkg::mix_mode_t mode,
   input  wire pixel_pkg::rgb_t      sprite_rgb,
   output logic                      hsync,
   output logic                      vsync,
   output logic                      red,
   output logic                      green,
   output logic                      blue,
   output logic                      active,
   output logic [9:0]                x,
   output logic [9:0]                y
);

   // eight equal bars across the line
   localparam logic [9:0] bar_width = h_active / 10'd8;

   vga_timing_pkg::pos_t  pos;
   vga_timing_pkg::sync_t sync;
   pixel_pkg::rgb_t       bar_rgb;
   pixel_pkg::rgb_t       mix_rgb;
   logic                  hit;

   // ------------------------------------------------------------
   // timing and color output
   // ------------------------------------------------------------
   vga_sync #(
      .h_active (h_active),
      .v_active (v_active),
      .h_fp     (h_fp),
      .h_sync   (h_sync),
      .h_bp     (h_bp),
      .v_fp     (v_fp),
      .v_sync   (v_sync),
      .v_bp     (v_bp)
   ) u_sync (
      .clk_36MHz (clk_36MHz),
      .rst       (rst),
      .mix_rgb   (mix_rgb),
      .pos       (pos),
      .sync      (sync),
      .red       (red),
      .green     (green),
      .blue      (blue)
   );

   // ------------------------------------------------------------
   // picture sources and mixer
   // ------------------------------------------------------------
   bar_pattern #(
      .bar_width (bar_width)
   ) u_bars (
      .clk_36MHz (clk_36MHz),
      .rst       (rst),
      .pos       (pos),
      .bar_rgb   (bar_rgb)
   );

   sprite_box #(
      .h_active    (h_active),
      .v_active    (v_active),
      .sprite_size (sprite_size)
   ) u_sprite (
      .clk_36MHz (clk_36MHz),
      .rst       (rst),
      .pos       (pos),
      .sync      (sync),
      .hit       (hit)
   );

   pixel_mixer u_mixer (
      .clk_36MHz  (clk_36MHz),
      .rst        (rst),
      .mode       (mode),
      .sprite_rgb (sprite_rgb),
      .sync       (sync),
      .bar_rgb    (bar_rgb),
      .hit        (hit),
      .mix_rgb    (mix_rgb)
   );

   // struct fields out to the pins
   assign hsync  = sync.hsync;
   assign vsync  = sync.vsync;
   assign active = pos.active;
   assign x      = pos.x;
   assign y      = pos.y;

endmodule

`default_nettype wire

// File: tb_vga_top.sv
`default_nettype none

module tb_vga_top;

   // small frame so a run of six frames stays short
   localparam int h_active = 64;
   localparam int v_active = 48;
   localparam int h_fp = 4;
   localparam int h_sync = 6;
   localparam int h_bp = 6;
   localparam int v_fp = 1;
   localparam int v_sync = 2;
   localparam int v_bp = 3;
   localparam int sprite_size = 8;
   localparam int bar_width = h_active / 8;

   localparam int h_blank = h_fp + h_sync + h_bp;
   localparam int v_blank = v_fp + v_sync + v_bp;
   localparam int h_total = h_blank + h_active;
   localparam int v_total = v_blank + v_active;
   localparam int frame_cycles = h_total * v_total;
   localparam int n_frames = 6;
   localparam int reset_cycles = 5;
   localparam int clk_period = 20;
   localparam int run_cycles = reset_cycles + n_frames * frame_cycles;
   localparam int watchdog_time = (run_cycles + 1000) * clk_period;

   // test indices for the per test counters
   localparam int t_reset = 0;
   localparam int t_sync = 1;
   localparam int t_pos = 2;
   localparam int t_bars = 3;
   localparam int t_sprite = 4;
   localparam int t_mix = 5;
   localparam int n_tests = 6;

   logic                 clk_36MHz;
   logic                 rst;
   pixel_pkg::mix_mode_t mode;
   pixel_pkg::rgb_t      sprite_rgb;
   logic                 hsync;
   logic                 vsync;
   logic                 red;
   logic                 green;
   logic                 blue;
   logic                 active;
   logic [9:0]           x;
   logic [9:0]           y;

   // model state as it stands after the last clock edge
   int                   m_hc;
   int                   m_vc;
   int                   m_x;
   int                   m_y;
   int                   m_sx;
   int                   m_sy;
   bit                   m_dx;
   bit                   m_dy;
   bit                   m_active;
   bit                   m_in_reset;
   bit                   m_valid;
   logic [2:0]           m_rgb;
   int                   m_rgb_cat;
   pixel_pkg::mix_mode_t m_mode;

   // inputs as the DUT sees them at the next edge
   logic                 cap_rst;
   pixel_pkg::mix_mode_t cap_mode;
   logic [2:0]           cap_rgb;

   int                   hs_low;
   int                   vs_low;
   int                   sched;
   int                   cyc;
   int                   total_checks;
   int                   total_errs;
   logic [31:0]          rng;
   int                   n_checks [n_tests];
   int                   n_errs [n_tests];
   string                test_name [n_tests] = '{"reset", "sync timing", "position",
                                                 "bars", "sprite", "mixing"};

   vga_top #(
      .h_active    (10'(h_active)),
      .v_active    (10'(v_active)),
      .h_fp        (10'(h_fp)),
      .h_sync      (10'(h_sync)),
      .h_bp        (10'(h_bp)),
      .v_fp        (10'(v_fp)),
      .v_sync      (10'(v_sync)),
      .v_bp        (10'(v_bp)),
      .sprite_size (10'(sprite_size))
   ) uut (
      .clk_36MHz  (clk_36MHz),
      .rst        (rst),
      .mode       (mode),
      .sprite_rgb (sprite_rgb),
      .hsync      (hsync),
      .vsync      (vsync),
      .red        (red),
      .green      (green),
      .blue       (blue),
      .active     (active),
      .x          (x),
      .y          (y)
   );

   initial
   begin
      clk_36MHz = 1'b0;
      forever #(clk_period / 2) clk_36MHz = ~clk_36MHz;
   end

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] v;
      v = s;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   // white yellow cyan green magenta red blue black
   function automatic logic [2:0] bar_color(input int idx);
      case (idx)
         0: return 3'b111;
         1: return 3'b110;
         2: return 3'b011;
         3: return 3'b010;
         4: return 3'b101;
         5: return 3'b100;
         6: return 3'b001;
         default: return 3'b000;
      endcase
   endfunction

   function automatic bit in_sprite(input int px, input int py);
      return (px >= m_sx) && (px < m_sx + sprite_size)
             && (py >= m_sy) && (py < m_sy + sprite_size);
   endfunction

   function automatic logic [2:0] mix_color(input pixel_pkg::mix_mode_t md,
                                            input logic [2:0] bar,
                                            input logic [2:0] spr,
                                            input bit h);
      case (md)
         pixel_pkg::sprite_over_bars: return h ? spr : bar;
         pixel_pkg::sprite_xor_bars: return h ? (bar ^ spr) : bar;
         pixel_pkg::sprite_only: return h ? spr : 3'b000;
         default: return bar;
      endcase
   endfunction

   // one pixel step that turns around at the limit
   task automatic step_axis(inout int p, inout bit d, input int lim);
      if (d)
      begin
         if (p == lim)
         begin
            d = 1'b0;
            p = p - 1;
         end
         else
            p = p + 1;
      end
      else if (p == 0)
      begin
         d = 1'b1;
         p = p + 1;
      end
      else
         p = p - 1;
   endtask

   task automatic compare_values(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, input int cat);
      n_checks[cat]++;
      if (got !== exp)
      begin
         n_errs[cat]++;
         $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // ------------------------------------------------------------
   // frame model with one call per rising edge
   // ------------------------------------------------------------
   task automatic advance_model();
      bit         fs;
      bit         act_now;
      logic [2:0] bar;
      fs = (m_hc == 0) && (m_vc == 0);
      if (cap_rst)
      begin
         m_hc = 0;
         m_vc = 0;
         m_active = 1'b0;
         m_x = 0;
         m_y = 0;
         m_rgb = 3'b000;
         m_rgb_cat = t_reset;
         m_sx = 0;
         m_sy = 0;
         m_dx = 1'b1;
         m_dy = 1'b1;
         m_mode = pixel_pkg::bars_only;
         m_in_reset = 1'b1;
      end
      else
      begin
         m_in_reset = 1'b0;
         // color pins take the mix of the previous position
         if (m_active)
         begin
            bar = bar_color(m_x / bar_width);
            m_rgb = mix_color(m_mode, bar, cap_rgb, in_sprite(m_x, m_y));
            if (m_mode == pixel_pkg::bars_only)
               m_rgb_cat = t_bars;
            else if (m_mode == pixel_pkg::sprite_only)
               m_rgb_cat = t_sprite;
            else
               m_rgb_cat = t_mix;
         end
         else
         begin
            // blanked pixel
            m_rgb = 3'b000;
            m_rgb_cat = t_bars;
         end
         act_now = (m_hc >= h_blank) && (m_vc >= v_blank);
         m_active = act_now;
         m_x = act_now ? m_hc - h_blank : 0;
         m_y = act_now ? m_vc - v_blank : 0;
         // sprite and mode move on only at frame start
         if (fs)
         begin
            step_axis(m_sx, m_dx, h_active - sprite_size);
            step_axis(m_sy, m_dy, v_active - sprite_size);
            m_mode = cap_mode;
         end
         if (m_hc == h_total - 1)
         begin
            m_hc = 0;
            m_vc = (m_vc == v_total - 1) ? 0 : m_vc + 1;
         end
         else
            m_hc = m_hc + 1;
      end
   endtask

   // ------------------------------------------------------------
   // output checks at the falling edge
   // ------------------------------------------------------------
   task automatic check_outputs();
      int c_sync;
      int c_pos;
      int c_col;
      int exp_hs;
      int exp_vs;
      c_sync = m_in_reset ? t_reset : t_sync;
      c_pos = m_in_reset ? t_reset : t_pos;
      c_col = m_in_reset ? t_reset : m_rgb_cat;
      // syncs low inside the window after front porch
      exp_hs = (m_hc >= h_fp && m_hc < h_fp + h_sync) ? 0 : 1;
      exp_vs = (m_vc >= v_fp && m_vc < v_fp + v_sync) ? 0 : 1;
      compare_values("hsync", 32'(hsync), exp_hs, c_sync);
      compare_values("vsync", 32'(vsync), exp_vs, c_sync);
      compare_values("active", 32'(active), 32'(m_active), c_pos);
      compare_values("x", 32'(x), m_x, c_pos);
      compare_values("y", 32'(y), m_y, c_pos);
      compare_values("rgb", 32'({red, green, blue}), 32'(m_rgb), c_col);
      // pulse widths over whole lines and frames
      if (m_in_reset)
      begin
         hs_low = 0;
         vs_low = 0;
      end
      else
      begin
         if (!hsync)
            hs_low++;
         if (!vsync)
            vs_low++;
         if (m_hc == h_total - 1)
         begin
            compare_values("hsync low cycles", hs_low, h_sync, t_sync);
            hs_low = 0;
         end
         if (m_hc == h_total - 1 && m_vc == v_total - 1)
         begin
            compare_values("vsync low cycles", vs_low, v_sync * h_total, t_sync);
            vs_low = 0;
         end
      end
   endtask

   // ------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------
   task automatic drive_inputs(input int c);
      logic [31:0] r;
      rng = xorshift(rng);
      r = rng;
      // the edge before the first model step is the first of the reset edges
      if (c == reset_cycles - 2)
         rst <= 1'b0;
      if (m_hc == h_total - 1 && m_vc == v_total - 1)
      begin
         // value at the frame edge walks through every mode
         mode <= pixel_pkg::mix_mode_t'(2'(sched));
         sched = (sched + 1) % 4;
      end
      else if (!(m_hc == 0 && m_vc == 0) && r[5:0] == 6'd0)
         // mid frame noise that must not reach the picture
         mode <= pixel_pkg::mix_mode_t'(r[7:6]);
      if (r[11:8] < 4'd5)
         sprite_rgb <= pixel_pkg::rgb_t'(r[14:12]);
   endtask

   initial
   begin
      rst <= 1'b1;
      mode <= pixel_pkg::bars_only;
      sprite_rgb <= pixel_pkg::rgb_t'(3'b000);
      rng = 32'h3e30;
      sched = 1;
      m_valid = 1'b0;
      hs_low = 0;
      vs_low = 0;
      for (int i = 0; i < n_tests; i++)
      begin
         n_checks[i] = 0;
         n_errs[i] = 0;
      end
      // first reset edge, ahead of the model
      @(posedge clk_36MHz);
      for (cyc = 0; cyc < run_cycles; cyc++)
      begin
         @(negedge clk_36MHz);
         if (m_valid)
            check_outputs();
         cap_rst = rst;
         cap_mode = mode;
         cap_rgb = sprite_rgb;
         @(posedge clk_36MHz);
         advance_model();
         m_valid = 1'b1;
         drive_inputs(cyc);
      end
      @(negedge clk_36MHz);
      check_outputs();

      total_checks = 0;
      total_errs = 0;
      for (int i = 0; i < n_tests; i++)
      begin
         $display("test %s done: %0d checks, %0d errors", test_name[i], n_checks[i],
                  n_errs[i]);
         total_checks += n_checks[i];
         total_errs += n_errs[i];
      end
      $display("tests %0d, checks %0d, errors %0d", n_tests, total_checks, total_errs);
      if (total_errs == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   // six frames plus reset with some slack
   initial
   begin
      #(watchdog_time);
      $display("timeout: the run did not end within %0d frames plus margin", n_frames);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
vga_timing_pkg.sv
pixel_pkg.sv
vga_sync.sv
bar_pattern.sv
sprite_box.sv
pixel_mixer.sv
vga_top.sv
tb_vga_top.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the VGA testbench with Verilator
# the run fails if the log holds the fail message

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tb_vga_top -f filelist.f
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/Vtb_vga_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TB FAILED" "$log"; then
   exit 1
fi
exit 0
